// ==== source/ingress_pkg.sv ====
// Single clock domain; the ingress ports carry no back-pressure
// NUM_PORTS and BUF_DEPTH must stay powers of two for the pointer wrap

`default_nettype none

package ingress_pkg;

    ////////////////////////////////////////
    // Converged bus

    // Bytes per converged word
    localparam int BUS_BYTES = 8;

    ////////////////////////////////////////
    // Physical ports

    localparam int NUM_PORTS        = 4;
    // Ports 0 and 1 are narrow, ports 2 and 3 are wide
    localparam int NUM_NARROW_PORTS = 2;
    localparam int NUM_WIDE_PORTS   = 2;
    localparam int NARROW_BYTES     = 1;
    localparam int WIDE_BYTES       = 4;
    localparam int PORT_IDX_BITS    = 2;

    ////////////////////////////////////////
    // Buffering

    // Words held per port buffer
    localparam int BUF_DEPTH = 16;

    ////////////////////////////////////////
    // Types

    typedef logic [BUS_BYTES*8-1:0]   bus_word_t;
    // Bit i marks byte i as valid
    typedef logic [BUS_BYTES-1:0]     bus_keep_t;
    typedef logic [PORT_IDX_BITS-1:0] port_idx_t;

endpackage

`default_nettype wire

// ==== source/ingress_width_adapt.sv ====
// IN_BYTES must divide BUS_BYTES; tkeep is contiguous from byte 0 and only partial on tlast
// Every packet starts a fresh word, so bytes never straddle two words

`timescale 1ns/1ps
`default_nettype none

module ingress_width_adapt #(
    parameter int IN_BYTES = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_tvalid,
    input  logic [IN_BYTES*8-1:0]  in_tdata,
    input  logic [IN_BYTES-1:0]    in_tkeep,
    input  logic                   in_tlast,
    output logic                   word_valid,
    output ingress_pkg::bus_word_t word_data,
    output ingress_pkg::bus_keep_t word_keep,
    output logic                   word_last
);

    // Byte counts run from 0 to BUS_BYTES inclusive
    logic [$clog2(ingress_pkg::BUS_BYTES+1)-1:0] fill_cnt;
    logic [$clog2(ingress_pkg::BUS_BYTES+1)-1:0] kept_cnt;
    logic [$clog2(ingress_pkg::BUS_BYTES+1)-1:0] fill_next;

    ingress_pkg::bus_word_t asm_data;
    ingress_pkg::bus_word_t next_data;
    ingress_pkg::bus_keep_t next_keep;
    logic                   word_done;

    ////////////////////////////////////////
    // Byte placement

    always_comb begin
        // A fresh word starts from zero so unused bytes read as zero
        next_data = (fill_cnt == '0) ? '0 : asm_data;
        kept_cnt  = '0;
        for (int i = 0; i < IN_BYTES; i++) begin
            if (in_tkeep[i] && (int'(fill_cnt) + i < ingress_pkg::BUS_BYTES)) begin
                next_data[(int'(fill_cnt) + i)*8 +: 8] = in_tdata[i*8 +: 8];
                kept_cnt = kept_cnt + 1'b1;
            end
        end
        fill_next = fill_cnt + kept_cnt;
        for (int b = 0; b < ingress_pkg::BUS_BYTES; b++) begin
            next_keep[b] = (b < int'(fill_next));
        end
    end

    // Emit on a full word or at the end of a packet
    assign word_done = in_tvalid && (in_tlast || (int'(fill_next) == ingress_pkg::BUS_BYTES));

    ////////////////////////////////////////
    // Registers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            if (word_done) begin
                fill_cnt <= '0;
            end else if (in_tvalid) begin
                fill_cnt <= fill_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_tvalid) begin
            asm_data <= next_data;
        end
        if (word_done) begin
            word_data <= next_data;
            word_keep <= next_keep;
            word_last <= in_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== source/ingress_port_buffer.sv ====
// Show-ahead FIFO; a push into a full buffer is dropped and flagged one cycle later
// The write side has no ready, so the producer never stalls

`timescale 1ns/1ps
`default_nettype none

module ingress_port_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_valid,
    input  ingress_pkg::bus_word_t word_data,
    input  ingress_pkg::bus_keep_t word_keep,
    input  logic                   word_last,
    output logic                   buf_tvalid,
    output ingress_pkg::bus_word_t buf_tdata,
    output ingress_pkg::bus_keep_t buf_tkeep,
    output logic                   buf_tlast,
    input  logic                   buf_tready,
    output logic                   overflow
);

    logic [$clog2(ingress_pkg::BUF_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(ingress_pkg::BUF_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(ingress_pkg::BUF_DEPTH+1)-1:0] count;

    ingress_pkg::bus_word_t mem_data [ingress_pkg::BUF_DEPTH];
    ingress_pkg::bus_keep_t mem_keep [ingress_pkg::BUF_DEPTH];
    logic                   mem_last [ingress_pkg::BUF_DEPTH];

    logic full;
    logic pop;
    logic push;

    assign full = (int'(count) == ingress_pkg::BUF_DEPTH);
    assign pop  = buf_tvalid && buf_tready;
    // A pop in the same cycle frees the slot for the push
    assign push = word_valid && (!full || pop);

    // Head entry is always on the read port
    assign buf_tvalid = (count != '0);
    assign buf_tdata  = mem_data[rd_ptr];
    assign buf_tkeep  = mem_keep[rd_ptr];
    assign buf_tlast  = mem_last[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overflow <= word_valid && !push;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= word_data;
            mem_keep[wr_ptr] <= word_keep;
            mem_last[wr_ptr] <= word_last;
        end
    end

endmodule

`default_nettype wire

// ==== source/ingress_arb_mux.sv ====
// Packet-level round robin; a grant holds until the word with tlast is taken
// An empty output register loads even while out_tready is low

`timescale 1ns/1ps
`default_nettype none

module ingress_arb_mux (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [ingress_pkg::NUM_PORTS-1:0]               buf_tvalid,
    input  ingress_pkg::bus_word_t [ingress_pkg::NUM_PORTS-1:0] buf_tdata,
    input  ingress_pkg::bus_keep_t [ingress_pkg::NUM_PORTS-1:0] buf_tkeep,
    input  logic [ingress_pkg::NUM_PORTS-1:0]               buf_tlast,
    output logic [ingress_pkg::NUM_PORTS-1:0]               buf_tready,
    output logic                                            out_tvalid,
    output ingress_pkg::bus_word_t                          out_tdata,
    output ingress_pkg::bus_keep_t                          out_tkeep,
    output logic                                            out_tlast,
    output ingress_pkg::port_idx_t                          out_tuser,
    input  logic                                            out_tready
);

    typedef enum logic {
        IDLE,
        PACKET
    } arb_state_t;

    arb_state_t             state;
    ingress_pkg::port_idx_t rr_ptr;
    ingress_pkg::port_idx_t grant;
    ingress_pkg::port_idx_t cand;
    ingress_pkg::port_idx_t search_idx;
    ingress_pkg::port_idx_t sel_port;
    logic                   found;
    logic                   sel_valid;
    logic                   load_en;
    logic                   take;

    ////////////////////////////////////////
    // Port selection

    // First requesting port at or above the pointer, with wrap
    always_comb begin
        search_idx = rr_ptr;
        cand       = rr_ptr;
        found      = 1'b0;
        for (int i = 0; i < ingress_pkg::NUM_PORTS; i++) begin
            cand = rr_ptr + ingress_pkg::port_idx_t'(i);
            if (!found && buf_tvalid[cand]) begin
                search_idx = cand;
                found      = 1'b1;
            end
        end
    end

    assign sel_port  = (state == PACKET) ? grant : search_idx;
    assign sel_valid = (state == PACKET) ? buf_tvalid[grant] : found;

    // Output register is free when empty or draining this cycle
    assign load_en = !out_tvalid || out_tready;
    assign take    = load_en && sel_valid;

    always_comb begin
        buf_tready = '0;
        if (take) begin
            buf_tready[sel_port] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Grant FSM and output register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            rr_ptr     <= '0;
            grant      <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (load_en) begin
                out_tvalid <= sel_valid;
            end
            if (take) begin
                if (buf_tlast[sel_port]) begin
                    state  <= IDLE;
                    rr_ptr <= sel_port + 1'b1;
                end else begin
                    state <= PACKET;
                    grant <= sel_port;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_tdata <= buf_tdata[sel_port];
            out_tkeep <= buf_tkeep[sel_port];
            out_tlast <= buf_tlast[sel_port];
            out_tuser <= sel_port;
        end
    end

endmodule

`default_nettype wire

// ==== source/router_ingress.sv ====
// Narrow ports map to indices 0 and 1, wide ports to 2 and 3 on out_tuser
// ing32_tkeep counts only on a last beat and must be contiguous from byte 0

`timescale 1ns/1ps
`default_nettype none

module router_ingress (
    input  logic                                            clk,
    input  logic                                            rst_n,

    input  logic [ingress_pkg::NUM_NARROW_PORTS-1:0]        ing8_tvalid,
    input  logic [ingress_pkg::NUM_NARROW_PORTS-1:0][ingress_pkg::NARROW_BYTES*8-1:0] ing8_tdata,
    input  logic [ingress_pkg::NUM_NARROW_PORTS-1:0]        ing8_tlast,

    input  logic [ingress_pkg::NUM_WIDE_PORTS-1:0]          ing32_tvalid,
    input  logic [ingress_pkg::NUM_WIDE_PORTS-1:0][ingress_pkg::WIDE_BYTES*8-1:0] ing32_tdata,
    input  logic [ingress_pkg::NUM_WIDE_PORTS-1:0][ingress_pkg::WIDE_BYTES-1:0]   ing32_tkeep,
    input  logic [ingress_pkg::NUM_WIDE_PORTS-1:0]          ing32_tlast,

    output logic                                            out_tvalid,
    output ingress_pkg::bus_word_t                          out_tdata,
    output ingress_pkg::bus_keep_t                          out_tkeep,
    output logic                                            out_tlast,
    output ingress_pkg::port_idx_t                          out_tuser,
    input  logic                                            out_tready,

    output logic [ingress_pkg::NUM_PORTS-1:0]               ing_buf_overflow
);

    // Adapter to buffer strobes
    logic [ingress_pkg::NUM_PORTS-1:0]                   word_valid;
    ingress_pkg::bus_word_t [ingress_pkg::NUM_PORTS-1:0] word_data;
    ingress_pkg::bus_keep_t [ingress_pkg::NUM_PORTS-1:0] word_keep;
    logic [ingress_pkg::NUM_PORTS-1:0]                   word_last;

    // Buffer to arbiter handshake
    logic [ingress_pkg::NUM_PORTS-1:0]                   buf_tvalid;
    ingress_pkg::bus_word_t [ingress_pkg::NUM_PORTS-1:0] buf_tdata;
    ingress_pkg::bus_keep_t [ingress_pkg::NUM_PORTS-1:0] buf_tkeep;
    logic [ingress_pkg::NUM_PORTS-1:0]                   buf_tlast;
    logic [ingress_pkg::NUM_PORTS-1:0]                   buf_tready;

    ////////////////////////////////////////
    // Width adapters

    // Narrow ports have no keep, every beat carries its byte
    for (genvar n = 0; n < ingress_pkg::NUM_NARROW_PORTS; n++) begin : narrow_adapt_g
        ingress_width_adapt #(
            .IN_BYTES   ( ingress_pkg::NARROW_BYTES )
        ) u_adapt (
            .clk        ( clk                                    ),
            .rst_n      ( rst_n                                  ),
            .in_tvalid  ( ing8_tvalid[n]                         ),
            .in_tdata   ( ing8_tdata[n]                          ),
            .in_tkeep   ( {ingress_pkg::NARROW_BYTES{1'b1}}      ),
            .in_tlast   ( ing8_tlast[n]                          ),
            .word_valid ( word_valid[n]                          ),
            .word_data  ( word_data[n]                           ),
            .word_keep  ( word_keep[n]                           ),
            .word_last  ( word_last[n]                           )
        );
    end

    for (genvar w = 0; w < ingress_pkg::NUM_WIDE_PORTS; w++) begin : wide_adapt_g
        ingress_width_adapt #(
            .IN_BYTES   ( ingress_pkg::WIDE_BYTES )
        ) u_adapt (
            .clk        ( clk                                         ),
            .rst_n      ( rst_n                                       ),
            .in_tvalid  ( ing32_tvalid[w]                             ),
            .in_tdata   ( ing32_tdata[w]                              ),
            .in_tkeep   ( ing32_tkeep[w]                              ),
            .in_tlast   ( ing32_tlast[w]                              ),
            .word_valid ( word_valid[ingress_pkg::NUM_NARROW_PORTS + w] ),
            .word_data  ( word_data[ingress_pkg::NUM_NARROW_PORTS + w]  ),
            .word_keep  ( word_keep[ingress_pkg::NUM_NARROW_PORTS + w]  ),
            .word_last  ( word_last[ingress_pkg::NUM_NARROW_PORTS + w]  )
        );
    end

    ////////////////////////////////////////
    // Port buffers

    for (genvar p = 0; p < ingress_pkg::NUM_PORTS; p++) begin : port_buf_g
        ingress_port_buffer u_buf (
            .clk        ( clk                 ),
            .rst_n      ( rst_n               ),
            .word_valid ( word_valid[p]       ),
            .word_data  ( word_data[p]        ),
            .word_keep  ( word_keep[p]        ),
            .word_last  ( word_last[p]        ),
            .buf_tvalid ( buf_tvalid[p]       ),
            .buf_tdata  ( buf_tdata[p]        ),
            .buf_tkeep  ( buf_tkeep[p]        ),
            .buf_tlast  ( buf_tlast[p]        ),
            .buf_tready ( buf_tready[p]       ),
            .overflow   ( ing_buf_overflow[p] )
        );
    end

    ////////////////////////////////////////
    // Merge onto the converged bus

    ingress_arb_mux u_arb (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .buf_tvalid ( buf_tvalid ),
        .buf_tdata  ( buf_tdata  ),
        .buf_tkeep  ( buf_tkeep  ),
        .buf_tlast  ( buf_tlast  ),
        .buf_tready ( buf_tready ),
        .out_tvalid ( out_tvalid ),
        .out_tdata  ( out_tdata  ),
        .out_tkeep  ( out_tkeep  ),
        .out_tlast  ( out_tlast  ),
        .out_tuser  ( out_tuser  ),
        .out_tready ( out_tready )
    );

endmodule

`default_nettype wire

// ==== testbench/ingress_model.svh ====
// Expected-word model of the converged bus, included inside router_ingress_tb
// Needs MAX_LEN from the including module; data is compared on kept bytes only

`ifndef INGRESS_MODEL_SVH
`define INGRESS_MODEL_SVH

typedef struct packed {
    ingress_pkg::port_idx_t port;
    logic                   last;
    ingress_pkg::bus_keep_t keep;
    ingress_pkg::bus_word_t data;
} exp_word_t;

// Expected words of all ports in arrival order, searched per port
exp_word_t  exp_q [$];
// Source port of each finished output packet
int         order_q [$];
logic [7:0] pkt_bytes [0:MAX_LEN-1];
logic       in_pkt;
int         pkt_port;
int         err_cnt;

////////////////////////////////////////
// Packing rule and round robin

// Bytes fill each word from byte 0, a packet always starts a fresh word
task automatic pack_expected(input int port, input int len);
    exp_word_t w;
    int        pos;
    w = '0;
    for (int b = 0; b < len; b++) begin
        pos = b % ingress_pkg::BUS_BYTES;
        if (pos == 0) begin
            w      = '0;
            w.port = ingress_pkg::port_idx_t'(port);
        end
        w.data[pos*8 +: 8] = pkt_bytes[b];
        w.keep[pos]        = 1'b1;
        if (pos == ingress_pkg::BUS_BYTES - 1 || b == len - 1) begin
            w.last = (b == len - 1);
            exp_q.push_back(w);
        end
    end
endtask

function automatic int pending_words(input int port);
    int n;
    n = 0;
    foreach (exp_q[i]) begin
        if (int'(exp_q[i].port) == port) begin
            n++;
        end
    end
    return n;
endfunction

// First requesting port at or above ptr, with wrap
function automatic int rr_next(input int ptr, input logic [ingress_pkg::NUM_PORTS-1:0] mask);
    int p;
    for (int i = 0; i < ingress_pkg::NUM_PORTS; i++) begin
        p = (ptr + i) % ingress_pkg::NUM_PORTS;
        if (mask[p]) begin
            return p;
        end
    end
    return -1;
endfunction

////////////////////////////////////////
// Output word check

task automatic check_word(input ingress_pkg::bus_word_t data, input ingress_pkg::bus_keep_t keep,
                          input logic last, input ingress_pkg::port_idx_t user);
    int                     idx;
    exp_word_t              e;
    ingress_pkg::bus_word_t mask;
    idx = -1;
    if (in_pkt && int'(user) != pkt_port) begin
        $display("At %0d ns a word from port %0d cut into the packet from port %0d",
                 $time, user, pkt_port);
        err_cnt++;
    end
    foreach (exp_q[i]) begin
        if (idx < 0 && exp_q[i].port == user) begin
            idx = i;
        end
    end
    if (idx < 0) begin
        $display("At %0d ns a word arrived on port %0d with no packet pending", $time, user);
        err_cnt++;
    end else begin
        e = exp_q[idx];
        for (int b = 0; b < ingress_pkg::BUS_BYTES; b++) begin
            mask[b*8 +: 8] = {8{e.keep[b]}};
        end
        if ((data & mask) !== (e.data & mask)) begin
            $display("** Error at %0d ns: out_tdata got %h expected %h", $time, data, e.data);
            err_cnt++;
        end
        if (keep !== e.keep) begin
            $display("** Error at %0d ns: out_tkeep got %h expected %h", $time, keep, e.keep);
            err_cnt++;
        end
        if (last !== e.last) begin
            $display("** Error at %0d ns: out_tlast got %b expected %b", $time, last, e.last);
            err_cnt++;
        end
        exp_q.delete(idx);
    end
    if (last) begin
        in_pkt = 1'b0;
        order_q.push_back(int'(user));
    end else begin
        in_pkt   = 1'b1;
        pkt_port = int'(user);
    end
endtask

`endif

// ==== testbench/router_ingress_tb.sv ====
// Drives one ingress port at a time; out_tready is randomized in the same loop
// Random data, lengths, gaps and ready come from one fixed seed

`timescale 1ns/1ps

module router_ingress_tb;

    localparam int MAX_LEN  = 24;
    localparam int MAX_GAP  = 3;
    localparam int N_RANDOM = 40;
    localparam int N_FLOOD  = 20;
    // Input beats, gap cycles and output words of the longest packet
    localparam int PKT_COST    = MAX_LEN + MAX_GAP + MAX_LEN / ingress_pkg::BUS_BYTES;
    localparam int CYCLE_LIMIT = 2 * ((8 + 2 * N_RANDOM) * PKT_COST + N_FLOOD * 4) + 2000;

    logic clk;
    logic rst_n;
    logic [ingress_pkg::NUM_NARROW_PORTS-1:0]                               ing8_tvalid;
    logic [ingress_pkg::NUM_NARROW_PORTS-1:0][ingress_pkg::NARROW_BYTES*8-1:0] ing8_tdata;
    logic [ingress_pkg::NUM_NARROW_PORTS-1:0]                               ing8_tlast;
    logic [ingress_pkg::NUM_WIDE_PORTS-1:0]                                 ing32_tvalid;
    logic [ingress_pkg::NUM_WIDE_PORTS-1:0][ingress_pkg::WIDE_BYTES*8-1:0]  ing32_tdata;
    logic [ingress_pkg::NUM_WIDE_PORTS-1:0][ingress_pkg::WIDE_BYTES-1:0]    ing32_tkeep;
    logic [ingress_pkg::NUM_WIDE_PORTS-1:0]                                 ing32_tlast;
    logic                                  out_tvalid;
    ingress_pkg::bus_word_t                out_tdata;
    ingress_pkg::bus_keep_t                out_tkeep;
    logic                                  out_tlast;
    ingress_pkg::port_idx_t                out_tuser;
    logic                                  out_tready;
    logic [ingress_pkg::NUM_PORTS-1:0]     ing_buf_overflow;

    int   seed;
    int   cycle_cnt;
    int   pass_cnt;
    int   fail_cnt;
    int   test_errs;
    int   ovf_cnt [ingress_pkg::NUM_PORTS];
    logic rand_ready;

    `include "ingress_model.svh"

    router_ingress UUT (
        .clk              ( clk              ),
        .rst_n            ( rst_n            ),
        .ing8_tvalid      ( ing8_tvalid      ),
        .ing8_tdata       ( ing8_tdata       ),
        .ing8_tlast       ( ing8_tlast       ),
        .ing32_tvalid     ( ing32_tvalid     ),
        .ing32_tdata      ( ing32_tdata      ),
        .ing32_tkeep      ( ing32_tkeep      ),
        .ing32_tlast      ( ing32_tlast      ),
        .out_tvalid       ( out_tvalid       ),
        .out_tdata        ( out_tdata        ),
        .out_tkeep        ( out_tkeep        ),
        .out_tlast        ( out_tlast        ),
        .out_tuser        ( out_tuser        ),
        .out_tready       ( out_tready       ),
        .ing_buf_overflow ( ing_buf_overflow )
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Monitor and timeout

    always @(posedge clk) begin
        if (rst_n && out_tvalid && out_tready) begin
            check_word(out_tdata, out_tkeep, out_tlast, out_tuser);
        end
        for (int i = 0; i < ingress_pkg::NUM_PORTS; i++) begin
            if (rst_n && ing_buf_overflow[i]) begin
                ovf_cnt[i]++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the converged bus stopped delivering after %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus tasks

    task automatic next_cycle();
        @(negedge clk);
        if (rand_ready) begin
            out_tready = (($random(seed) & 3) != 0);
        end
    endtask

    task automatic send_packet(input int port, input int len, input bit keep_it);
        int w;
        int nbytes;
        for (int b = 0; b < len; b++) begin
            pkt_bytes[b] = $random(seed);
        end
        if (keep_it) begin
            pack_expected(port, len);
        end
        if (port < ingress_pkg::NUM_NARROW_PORTS) begin
            for (int b = 0; b < len; b++) begin
                ing8_tvalid[port] = 1'b1;
                ing8_tdata[port]  = pkt_bytes[b];
                ing8_tlast[port]  = (b == len - 1);
                next_cycle();
            end
            ing8_tvalid[port] = 1'b0;
            ing8_tlast[port]  = 1'b0;
        end else begin
            w = port - ingress_pkg::NUM_NARROW_PORTS;
            for (int b = 0; b < len; b += ingress_pkg::WIDE_BYTES) begin
                nbytes = (len - b < ingress_pkg::WIDE_BYTES) ? len - b : ingress_pkg::WIDE_BYTES;
                ing32_tvalid[w] = 1'b1;
                ing32_tlast[w]  = (b + ingress_pkg::WIDE_BYTES >= len);
                for (int k = 0; k < ingress_pkg::WIDE_BYTES; k++) begin
                    ing32_tkeep[w][k]        = (k < nbytes);
                    ing32_tdata[w][k*8 +: 8] = (k < nbytes) ? pkt_bytes[b+k] : 8'($random(seed));
                end
                next_cycle();
            end
            ing32_tvalid[w] = 1'b0;
            ing32_tlast[w]  = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || out_tvalid) begin
            next_cycle();
        end
    endtask

    task automatic run_random(input int n);
        int port;
        int len;
        int gap;
        int nwords;
        for (int i = 0; i < n; i++) begin
            port   = $unsigned($random(seed)) % ingress_pkg::NUM_PORTS;
            len    = 1 + $unsigned($random(seed)) % MAX_LEN;
            gap    = $unsigned($random(seed)) % (MAX_GAP + 1);
            nwords = (len + ingress_pkg::BUS_BYTES - 1) / ingress_pkg::BUS_BYTES;
            // Hold off until the port's buffer has room for the whole packet
            while (pending_words(port) + nwords > ingress_pkg::BUF_DEPTH) begin
                next_cycle();
            end
            send_packet(port, len, 1'b1);
            repeat (gap) next_cycle();
        end
        wait_drain();
    endtask

    task automatic check_overflow(input int port, input int expected);
        if (ovf_cnt[port] != expected) begin
            $display("** Error at %0d ns: ing_buf_overflow[%0d] pulses got %0d expected %0d",
                     $time, port, ovf_cnt[port], expected);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (err_cnt == test_errs) begin
            pass_cnt++;
            $display("Test %0d %s: PASS", num, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: FAIL with %0d errors", num, name, err_cnt - test_errs);
        end
        test_errs = err_cnt;
    endtask

    ////////////////////////////////////////
    // Test sequence

    initial begin
        int                                load_order [ingress_pkg::NUM_PORTS];
        int                                pkt_len    [ingress_pkg::NUM_PORTS];
        int                                exp_order  [ingress_pkg::NUM_PORTS];
        logic [ingress_pkg::NUM_PORTS-1:0] mask;
        int                                nxt;
        int                                kept;

        clk          = 1'b0;
        rst_n        = 1'b0;
        ing8_tvalid  = '0;
        ing8_tdata   = '0;
        ing8_tlast   = '0;
        ing32_tvalid = '0;
        ing32_tdata  = '0;
        ing32_tkeep  = '0;
        ing32_tlast  = '0;
        out_tready   = 1'b0;
        rand_ready   = 1'b0;
        seed         = 32'h6d17_50c0;
        cycle_cnt    = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        test_errs    = 0;
        err_cnt      = 0;
        in_pkt       = 1'b0;
        pkt_port     = 0;
        foreach (ovf_cnt[i]) ovf_cnt[i] = 0;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Test 1 sends one packet per port with a partial last word
        if (out_tvalid !== 1'b0) begin
            $display("** Error at %0d ns: out_tvalid got %b expected 0", $time, out_tvalid);
            err_cnt++;
        end
        if (ing_buf_overflow !== '0) begin
            $display("** Error at %0d ns: ing_buf_overflow got %b expected 0",
                     $time, ing_buf_overflow);
            err_cnt++;
        end
        out_tready = 1'b1;
        send_packet(0, 11, 1'b1);
        send_packet(1, 5, 1'b1);
        send_packet(2, 13, 1'b1);
        send_packet(3, 22, 1'b1);
        wait_drain();
        finish_test(1, "single packets");

        // Test 2 parks packets behind a stalled output
        load_order = '{0, 3, 1, 2};
        pkt_len    = '{12, 20, 7, 9};
        out_tready = 1'b0;
        order_q.delete();
        foreach (load_order[i]) send_packet(load_order[i], pkt_len[load_order[i]], 1'b1);
        // The empty output register takes the first loaded port at once
        mask = '1;
        nxt  = load_order[0];
        for (int i = 0; i < ingress_pkg::NUM_PORTS; i++) begin
            exp_order[i] = nxt;
            mask[nxt]    = 1'b0;
            nxt          = rr_next(nxt + 1, mask);
        end
        out_tready = 1'b1;
        wait_drain();
        foreach (exp_order[i]) begin
            if (i >= order_q.size()) begin
                $display("Packet %0d of the round-robin test never left the converged bus", i);
                err_cnt++;
            end else if (order_q[i] != exp_order[i]) begin
                $display("** Error at %0d ns: out_tuser of packet %0d got %0d expected %0d",
                         $time, i, order_q[i], exp_order[i]);
                err_cnt++;
            end
        end
        finish_test(2, "round-robin order");

        // Test 3 runs random traffic under random back-pressure
        foreach (ovf_cnt[i]) ovf_cnt[i] = 0;
        rand_ready = 1'b1;
        run_random(N_RANDOM);
        foreach (ovf_cnt[i]) check_overflow(i, 0);
        finish_test(3, "random traffic");

        // Test 4 floods port 2 while the output is stalled
        rand_ready = 1'b0;
        out_tready = 1'b0;
        foreach (ovf_cnt[i]) ovf_cnt[i] = 0;
        order_q.delete();
        // The output register holds one word beyond the buffer
        kept = ingress_pkg::BUF_DEPTH + 1;
        for (int i = 0; i < N_FLOOD; i++) begin
            send_packet(2, ingress_pkg::BUS_BYTES, i < kept);
            next_cycle();
        end
        // Adapter and buffer each add one cycle before the flag
        repeat (3) next_cycle();
        foreach (ovf_cnt[i]) check_overflow(i, (i == 2) ? N_FLOOD - kept : 0);
        out_tready = 1'b1;
        wait_drain();
        if (order_q.size() != kept) begin
            $display("Port 2 delivered %0d packets instead of %0d", order_q.size(), kept);
            err_cnt++;
        end
        finish_test(4, "overflow");

        // Test 5 repeats random traffic after the drops
        foreach (ovf_cnt[i]) ovf_cnt[i] = 0;
        rand_ready = 1'b1;
        run_random(N_RANDOM);
        foreach (ovf_cnt[i]) check_overflow(i, 0);
        finish_test(5, "recovery");

        rand_ready = 1'b0;
        $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== router_ingress.f ====
+incdir+testbench
source/ingress_pkg.sv
source/ingress_width_adapt.sv
source/ingress_port_buffer.sv
source/ingress_arb_mux.sv
source/router_ingress.sv
testbench/router_ingress_tb.sv
